// File: logic/board_cfg_pkg.sv
// Board I/O configuration constants
package board_cfg_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Front-panel buttons
	////////////////////////////////////////////////////////////////////////////

	// Index 0 is user, index 1 is OSD
	localparam int unsigned NUM_BTNS = 2;

	// Samples held in one debounce window
	localparam int unsigned DEB_DEPTH = 8;

	// Clock cycles between debounce samples
	localparam int unsigned TICK_DIV_DEFAULT = 100000;

	////////////////////////////////////////////////////////////////////////////
	// Main-board LEDs and audio
	////////////////////////////////////////////////////////////////////////////

	localparam int unsigned LED_W = 8;

	localparam int unsigned VOL_W = 5;

	// Full mute out of reset
	localparam logic [VOL_W-1:0] VOL_RESET = 5'd31;

endpackage

// File: logic/host_cmd_pkg.sv
// Host command port definitions
package host_cmd_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Word bus
	////////////////////////////////////////////////////////////////////////////

	localparam int unsigned HOST_W = 16;

	// Opcode sits in the low byte of the first word
	typedef enum logic [7:0] {
		OP_VERSION = 8'h20,
		OP_LED_OVR = 8'h25,
		OP_VOL_ATT = 8'h26
	} host_opcode_e;

	// Returned on OP_VERSION
	localparam logic [HOST_W-1:0] IO_VERSION = 16'd3;

	////////////////////////////////////////////////////////////////////////////
	// Decoder FSM
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic {
		ST_OPCODE = 1'b0,
		ST_DATA   = 1'b1
	} dec_state_e;

endpackage

// File: logic/host_cmd_decoder.sv
// Host command decoder
module host_cmd_decoder
	import board_cfg_pkg::*;
	import host_cmd_pkg::*;
(
	input  logic              clk_sys,
	input  logic              resetd,
	input  logic              i_io_sel,
	input  logic              i_io_clk,
	input  logic [HOST_W-1:0] i_io_din,
	output logic              o_io_ack,
	output logic [HOST_W-1:0] o_io_dout,
	output logic [VOL_W-1:0]  o_vol_att,
	output logic [LED_W-1:0]  o_led_mask,
	output logic [LED_W-1:0]  o_led_state
);

	logic         io_clk_q;
	logic         io_strobe;
	dec_state_e   state;
	host_opcode_e opcode;

	////////////////////////////////////////////////////////////////////////////
	// Strobe and acknowledge
	////////////////////////////////////////////////////////////////////////////

	// One cycle per rising edge of the host clock
	assign io_strobe = i_io_clk & ~io_clk_q;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			io_clk_q <= 1'b0;
			o_io_ack <= 1'b0;
		end else begin
			io_clk_q <= i_io_clk;
			o_io_ack <= io_clk_q;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Command handling
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (i_io_sel && io_strobe && state == ST_OPCODE) begin
			opcode <= host_opcode_e'(i_io_din[7:0]);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			state       <= ST_OPCODE;
			o_io_dout   <= '0;
			o_vol_att   <= VOL_RESET;
			o_led_mask  <= '0;
			o_led_state <= '0;
		end else if (!i_io_sel) begin
			state     <= ST_OPCODE;
			o_io_dout <= '0;
		end else if (io_strobe) begin
			// Readback lasts until the next word
			o_io_dout <= '0;
			if (state == ST_OPCODE) begin
				state <= ST_DATA;
				if (i_io_din[7:0] == OP_VERSION) begin
					o_io_dout <= IO_VERSION;
				end
			end else begin
				case (opcode)
					OP_LED_OVR: {o_led_mask, o_led_state} <= i_io_din;
					OP_VOL_ATT: o_vol_att <= i_io_din[VOL_W-1:0];
					default: ;
				endcase
			end
		end
	end

endmodule

// File: logic/debounce_tick.sv
// Debounce sampling tick
module debounce_tick
	import board_cfg_pkg::*;
#(
	parameter int unsigned TICK_DIV = TICK_DIV_DEFAULT
) (
	input  logic clk_sys,
	input  logic resetd,
	output logic o_tick
);

	localparam int unsigned CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

	logic [CNT_W-1:0] div_cnt;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			div_cnt <= '0;
			o_tick  <= 1'b0;
		end else if (div_cnt == CNT_W'(TICK_DIV - 1)) begin
			div_cnt <= '0;
			o_tick  <= 1'b1;
		end else begin
			div_cnt <= div_cnt + 1'b1;
			o_tick  <= 1'b0;
		end
	end

endmodule

// File: logic/button_debouncer.sv
// Button debouncer
module button_debouncer
	import board_cfg_pkg::*;
(
	input  logic clk_sys,
	input  logic resetd,
	input  logic i_tick,
	input  logic i_pressed,
	output logic o_pressed
);

	logic [DEB_DEPTH-1:0] window;

	// Sample window, oldest sample at the top
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			window <= '0;
		end else if (i_tick) begin
			window <= {window[DEB_DEPTH-2:0], i_pressed};
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Hysteresis
	////////////////////////////////////////////////////////////////////////////

	// Mixed window keeps the last settled value
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_pressed <= 1'b0;
		end else if (&window) begin
			o_pressed <= 1'b1;
		end else if (~|window) begin
			o_pressed <= 1'b0;
		end
	end

endmodule

// File: logic/status_led_mux.sv
// Main-board LED merge
module status_led_mux
	import board_cfg_pkg::*;
(
	input  logic                clk_sys,
	input  logic                resetd,
	input  logic [LED_W-1:0]    i_led_mask,
	input  logic [LED_W-1:0]    i_led_state,
	input  logic [NUM_BTNS-1:0] i_btn,
	output logic [LED_W-1:0]    o_led
);

	logic [LED_W-1:0] dflt_pattern;
	logic [LED_W-1:0] led_next;

	// Buttons on the low bits, rest dark
	always_comb begin
		dflt_pattern = '0;
		dflt_pattern[NUM_BTNS-1:0] = i_btn;
	end

	// Host value where masked, default elsewhere
	assign led_next = (i_led_mask & i_led_state) | (~i_led_mask & dflt_pattern);

	////////////////////////////////////////////////////////////////////////////
	// Output stage
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_led <= '0;
		end else begin
			o_led <= led_next;
		end
	end

endmodule

// File: logic/board_io_top.sv
// Board I/O controller
module board_io_top
	import board_cfg_pkg::*;
	import host_cmd_pkg::*;
#(
	parameter int unsigned TICK_DIV = TICK_DIV_DEFAULT
) (
	input  logic                clk_sys,
	input  logic                resetd,
	input  logic                i_io_sel,
	input  logic                i_io_clk,
	input  logic [HOST_W-1:0]   i_io_din,
	input  logic [NUM_BTNS-1:0] i_btn_n,
	output logic                o_io_ack,
	output logic [HOST_W-1:0]   o_io_dout,
	output logic [VOL_W-1:0]    o_vol_att,
	output logic [LED_W-1:0]    o_led
);

	logic [LED_W-1:0]    led_mask;
	logic [LED_W-1:0]    led_state;
	logic                deb_tick;
	logic [NUM_BTNS-1:0] btn_deb;

	host_cmd_decoder u_decoder (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_io_sel    (i_io_sel),
		.i_io_clk    (i_io_clk),
		.i_io_din    (i_io_din),
		.o_io_ack    (o_io_ack),
		.o_io_dout   (o_io_dout),
		.o_vol_att   (o_vol_att),
		.o_led_mask  (led_mask),
		.o_led_state (led_state)
	);

	////////////////////////////////////////////////////////////////////////////
	// Buttons
	////////////////////////////////////////////////////////////////////////////

	debounce_tick #(
		.TICK_DIV (TICK_DIV)
	) u_tick (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.o_tick  (deb_tick)
	);

	// Pins are active low
	for (genvar i = 0; i < NUM_BTNS; i++) begin : g_btn
		button_debouncer u_deb (
			.clk_sys   (clk_sys),
			.resetd    (resetd),
			.i_tick    (deb_tick),
			.i_pressed (~i_btn_n[i]),
			.o_pressed (btn_deb[i])
		);
	end

	status_led_mux u_led (
		.clk_sys     (clk_sys),
		.resetd      (resetd),
		.i_led_mask  (led_mask),
		.i_led_state (led_state),
		.i_btn       (btn_deb),
		.o_led       (o_led)
	);

endmodule

// File: tests/tb_clock.sv
// Testbench clock source
module tb_clock (
	output logic o_clk_sys
);

	timeunit 1ns;
	timeprecision 1ps;

	// 4 ns period
	localparam realtime HALF_PERIOD = 2.0;

	initial begin
		o_clk_sys = 1'b0;
		forever #(HALF_PERIOD) o_clk_sys = ~o_clk_sys;
	end

endmodule

// File: tests/board_io_checker.sv
// Host decoder assertions
module board_io_checker
	import host_cmd_pkg::*;
(
	input logic              clk_sys,
	input logic              resetd,
	input logic              i_io_sel,
	input logic              i_io_strobe,
	input logic [HOST_W-1:0] i_io_dout,
	input logic              i_io_ack
);

	timeunit 1ns;
	timeprecision 1ps;

	int unsigned fail_count = 0;

	// One strobe per host clock edge
	a_strobe_single: assert property (@(posedge clk_sys) disable iff (resetd)
		i_io_strobe |=> !i_io_strobe)
		else begin
			fail_count++;
			$error("Host strobe lasted two cycles");
		end

	// Readback cleared once the chip select is gone
	a_dout_cleared: assert property (@(posedge clk_sys) disable iff (resetd)
		!i_io_sel |=> (i_io_dout == '0))
		else begin
			fail_count++;
			$error("o_io_dout not zero after i_io_sel was low");
		end

	a_ack_in_reset: assert property (@(posedge clk_sys) resetd |=> !i_io_ack)
		else begin
			fail_count++;
			$error("o_io_ack high during reset");
		end

endmodule

bind host_cmd_decoder board_io_checker u_checker (
	.clk_sys     (clk_sys),
	.resetd      (resetd),
	.i_io_sel    (i_io_sel),
	.i_io_strobe (io_strobe),
	.i_io_dout   (o_io_dout),
	.i_io_ack    (o_io_ack)
);

// File: tests/board_io_tb.sv
// Board I/O controller testbench
module board_io_tb
	import board_cfg_pkg::*;
	import host_cmd_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int unsigned TICK_DIV    = 8;
	localparam int unsigned NUM_ROWS    = 10;
	localparam int unsigned ACK_TIMEOUT = 10;
	localparam int unsigned DEB_TIMEOUT = 12 * TICK_DIV + 2;

	typedef struct {
		string             name;
		logic [7:0]        opcode;
		logic [HOST_W-1:0] data;
		logic [LED_W-1:0]  exp_led;
		logic [VOL_W-1:0]  exp_vol;
	} stim_row_t;

	stim_row_t           stim_table [NUM_ROWS];
	logic [31:0]         rng_state;
	logic [LED_W-1:0]    led_model;
	logic [VOL_W-1:0]    vol_model;
	logic                clk_sys;
	logic                resetd;
	logic                i_io_sel;
	logic                i_io_clk;
	logic [HOST_W-1:0]   i_io_din;
	logic [NUM_BTNS-1:0] i_btn_n;
	logic                o_io_ack;
	logic [HOST_W-1:0]   o_io_dout;
	logic [VOL_W-1:0]    o_vol_att;
	logic [LED_W-1:0]    o_led;

	tb_clock u_clock (
		.o_clk_sys (clk_sys)
	);

	board_io_top #(
		.TICK_DIV (TICK_DIV)
	) u_board_io_top (
		.clk_sys   (clk_sys),
		.resetd    (resetd),
		.i_io_sel  (i_io_sel),
		.i_io_clk  (i_io_clk),
		.i_io_din  (i_io_din),
		.i_btn_n   (i_btn_n),
		.o_io_ack  (o_io_ack),
		.o_io_dout (o_io_dout),
		.o_vol_att (o_vol_att),
		.o_led     (o_led)
	);

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic abort_run();
		$display("Test FAILED");
		$fatal(1, "Simulation stopped on first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("[FAIL] %s expected 0x%0h actual 0x%0h", name, expected, actual);
			abort_run();
		end
	endtask

	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic wait_ack(input logic level, input string what);
		int unsigned n;
		n = 0;
		while (o_io_ack !== level) begin
			if (n == ACK_TIMEOUT) begin
				$display("Timeout: o_io_ack never went to %0b during %s", level, what);
				abort_run();
			end else begin
				n++;
				next_cycle();
			end
		end
	endtask

	task automatic wait_led_bit(input int idx, input logic level, input string what);
		int unsigned n;
		n = 0;
		while (o_led[idx] !== level) begin
			if (n == DEB_TIMEOUT) begin
				$display("Timeout: o_led bit %0d never went to %0b after %s", idx, level, what);
				abort_run();
			end else begin
				n++;
				next_cycle();
			end
		end
	endtask

	// Rising host clock edge with the word on the bus
	task automatic start_word(input logic [HOST_W-1:0] word);
		i_io_din = word;
		i_io_clk = 1'b1;
	endtask

	// Three cycles high, three low, paced by the acknowledge
	task automatic finish_word(input string what);
		wait_ack(1'b1, what);
		next_cycle();
		i_io_clk = 1'b0;
		wait_ack(1'b0, what);
		next_cycle();
	endtask

	task automatic send_word(input logic [HOST_W-1:0] word, input string what);
		start_word(word);
		finish_word(what);
	endtask

	// Expected values follow the opcode rules, buttons released
	task automatic add_row(input int idx, input string name, input logic [7:0] opcode,
		input logic [HOST_W-1:0] data);
		if (opcode == OP_LED_OVR) begin
			led_model = data[15:8] & data[7:0];
		end else if (opcode == OP_VOL_ATT) begin
			vol_model = data[VOL_W-1:0];
		end
		stim_table[idx] = '{name, opcode, data, led_model, vol_model};
	endtask

	always @(posedge clk_sys) begin
		if (u_board_io_top.u_decoder.u_checker.fail_count != 0) begin
			$display("An assertion on the host command decoder failed");
			abort_run();
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		resetd    = 1'b1;
		i_io_sel  = 1'b0;
		i_io_clk  = 1'b0;
		i_io_din  = '0;
		i_btn_n   = '1;
		rng_state = 32'd27;
		led_model = '0;
		vol_model = VOL_RESET;
		for (int i = 0; i < 4; i++) begin
			rng_state = xorshift32(rng_state);
			add_row(i, $sformatf("led_ovr_%0d", i), OP_LED_OVR, rng_state[HOST_W-1:0]);
		end
		add_row(4, "vol_att_0c", OP_VOL_ATT, 16'hA50C);
		add_row(5, "vol_att_13", OP_VOL_ATT, 16'h0013);
		add_row(6, "unknown_30", 8'h30, 16'hFFFF);
		add_row(7, "vol_att_00", OP_VOL_ATT, 16'hFFE0);
		add_row(8, "unknown_21", 8'h21, 16'h1234);
		add_row(9, "led_ovr_clear", OP_LED_OVR, 16'h0000);

		repeat (10) @(posedge clk_sys);
		#1;
		resetd = 1'b0;
		check_value("reset_led", '0, o_led);
		check_value("reset_vol", VOL_RESET, o_vol_att);
		check_value("reset_dout", '0, o_io_dout);
		check_value("reset_ack", 1'b0, o_io_ack);

		for (int i = 0; i < NUM_ROWS; i++) begin
			i_io_sel = 1'b1;
			send_word({8'h00, stim_table[i].opcode}, stim_table[i].name);
			start_word(stim_table[i].data);
			// Data word reaches the LEDs two cycles after the strobe
			repeat (2) next_cycle();
			check_value({stim_table[i].name, " led"}, stim_table[i].exp_led, o_led);
			check_value({stim_table[i].name, " vol"}, stim_table[i].exp_vol, o_vol_att);
			finish_word(stim_table[i].name);
			i_io_sel = 1'b0;
			next_cycle();
		end

		// Readback ends on deselect and on the next word
		i_io_sel = 1'b1;
		send_word({8'h00, OP_VERSION}, "version opcode");
		check_value("version_readback", IO_VERSION, o_io_dout);
		i_io_sel = 1'b0;
		next_cycle();
		check_value("version_deselect", '0, o_io_dout);
		i_io_sel = 1'b1;
		send_word({8'h00, OP_VERSION}, "version opcode");
		check_value("version_again", IO_VERSION, o_io_dout);
		send_word(16'h5A5A, "version data");
		check_value("version_next_word", '0, o_io_dout);
		check_value("version_vol", vol_model, o_vol_att);
		i_io_sel = 1'b0;
		next_cycle();

		i_btn_n[0] = 1'b0;
		wait_led_bit(0, 1'b1, "user press");
		check_value("user_pressed", 8'h01, o_led);
		// OSD glitch of five ticks
		i_btn_n[1] = 1'b0;
		repeat (5 * TICK_DIV) next_cycle();
		i_btn_n[1] = 1'b1;
		for (int n = 0; n < DEB_TIMEOUT; n++) begin
			check_value("osd_glitch", 1'b0, o_led[1]);
			next_cycle();
		end
		i_btn_n[0] = 1'b1;
		wait_led_bit(0, 1'b0, "user release");
		check_value("user_released", '0, o_led);

		if (u_board_io_top.u_decoder.u_checker.fail_count != 0) begin
			$display("An assertion on the host command decoder failed");
			abort_run();
		end else begin
			$display("Test OK");
			$finish;
		end
	end

endmodule

// File: list.f
logic/board_cfg_pkg.sv
logic/host_cmd_pkg.sv
logic/host_cmd_decoder.sv
logic/debounce_tick.sv
logic/button_debouncer.sv
logic/status_led_mux.sv
logic/board_io_top.sv
tests/tb_clock.sv
tests/board_io_checker.sv
tests/board_io_tb.sv

// File: Bender.yml
package:
  name: board_io

sources:
  - logic/board_cfg_pkg.sv
  - logic/host_cmd_pkg.sv
  - logic/host_cmd_decoder.sv
  - logic/debounce_tick.sv
  - logic/button_debouncer.sv
  - logic/status_led_mux.sv
  - logic/board_io_top.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/board_io_checker.sv
      - tests/board_io_tb.sv
